//--- sources.f
verilog/dcache_pkg.sv
verilog/dcache_array_if.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_lru.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tests/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/dcache_array_if.sv
  - verilog/dcache_tag_array.sv
  - verilog/dcache_data_array.sv
  - verilog/dcache_lru.sv
  - verilog/dcache_ctrl.sv
  - verilog/dcache_top.sv
  - target: test
    files:
      - tests/tb_dcache.sv

//--- tests/tb_dcache.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// dcache testbench
// line wide memory model with random ready and return
// delays, golden word memory, directed and random traffic
////////////////////////////////////////////////////////////
module tb_dcache;
    import dcache_pkg::*;

    localparam int rand_req = 300;
    localparam int num_req  = rand_req + 14;  // directed requests on top

    logic        clk, rst_n, req_valid, req_op, busy, rdata_valid;
    logic [31:0] req_addr, mem_rd_addr, mem_wr_addr;
    strb_t       req_wstrb;
    word_t       req_wdata, rdata;
    logic        mem_rd_req, mem_wr_req, mem_rd_rdy, mem_ret_valid, mem_wr_rdy, mem_wr_done;
    line_t       mem_wr_data, mem_ret_data;

    word_t       backing [logic [31:0]];  // memory behind the cache
    word_t       golden [logic [31:0]];   // every accepted store lands here
    word_t       exp_q [$];               // expected load data, in order
    logic [31:0] rd_addrs [$];
    logic [31:0] wr_addrs [$];
    int          value_errors, other_errors;
    string       test_name;

    dcache_top #(.set_num(16)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // pattern over the whole address
    function automatic word_t fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    // reference model of a load
    function automatic word_t expected_load(input logic [31:0] addr);
        logic [31:0] wa;
        wa = {addr[31:2], 2'b00};
        if (golden.exists(wa))
            return golden[wa];
        return fill_word(wa);
    endfunction

    function automatic word_t strobe_merge(input word_t old_w, input word_t new_w,
                                           input strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[8*b +: 8] = new_w[8*b +: 8];  // byte lane enabled
        end
        return res;
    endfunction

    function automatic line_t golden_line(input logic [31:0] base);
        line_t l;
        for (int i = 0; i < line_word_num; i++)
            l[32*i +: 32] = expected_load(base + 4*i);
        return l;
    endfunction

    function automatic line_t memory_line(input logic [31:0] base);
        line_t l;
        for (int i = 0; i < line_word_num; i++)
            l[32*i +: 32] = backing.exists(base + 4*i) ? backing[base + 4*i] : fill_word(base + 4*i);
        return l;
    endfunction

    task automatic value_mismatch(input string tst, input logic [127:0] exp, input logic [127:0] act);
        value_errors++;
        $display("** Error [%s] expected %0h actual %0h", tst, exp, act);
    endtask

    task automatic protocol_fault(input string msg);
        other_errors++;
        $display("** Error [%s] %s", test_name, msg);
    endtask

    task automatic check_idle();
        assert (!busy && !rdata_valid && !mem_rd_req && !mem_wr_req)
        else protocol_fault("outputs not idle around reset");
    endtask

    task automatic random_delay();
        repeat ($urandom % 4) begin
            @(posedge clk);
            #2;
        end
    endtask

    // write-back payload must equal the golden line
    task automatic serve_write();
        logic [31:0] a;
        line_t       d;
        a = mem_wr_addr;
        d = mem_wr_data;
        wr_addrs.push_back(a);
        assert (d === golden_line(a))
        else value_mismatch({test_name, " write-back"}, golden_line(a), d);
        random_delay();
        mem_wr_rdy = 1'b1;
        @(posedge clk);
        #2 mem_wr_rdy = 1'b0;
        random_delay();
        mem_wr_done = 1'b1;  // one cycle pulse
        @(posedge clk);
        #2 mem_wr_done = 1'b0;
        for (int i = 0; i < line_word_num; i++)
            backing[a + 4*i] = d[32*i +: 32];
    endtask

    task automatic serve_read();
        logic [31:0] a;
        a = mem_rd_addr;
        rd_addrs.push_back(a);
        assert (a[3:0] == 4'h0) else protocol_fault("refill address not line aligned");
        random_delay();
        mem_rd_rdy = 1'b1;
        @(posedge clk);
        #2 mem_rd_rdy = 1'b0;
        random_delay();
        mem_ret_data  = memory_line(a);
        mem_ret_valid = 1'b1;
        @(posedge clk);
        #2 mem_ret_valid = 1'b0;
    endtask

    initial begin : mem_model
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_wr_rdy    = 1'b0;
        mem_wr_done   = 1'b0;
        mem_ret_data  = '0;
        @(posedge clk);
        #2;
        forever begin
            if (mem_wr_req) begin
                serve_write();
            end else if (mem_rd_req) begin
                serve_read();
            end else begin
                @(posedge clk);
                #2;
            end
        end
    end

    // compare every returned load against the reference
    always @(negedge clk) begin
        if (rst_n && rdata_valid) begin
            assert (exp_q.size() != 0) else protocol_fault("rdata_valid with no load pending");
            if (exp_q.size() != 0) begin
                assert (rdata === exp_q[0]) else value_mismatch(test_name, exp_q[0], rdata);
                void'(exp_q.pop_front());
            end
        end
    end

    // holds the request until an edge with busy low
    task automatic send(input logic op, input logic [31:0] addr, input strb_t strb,
                        input word_t data);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wstrb = strb;
        req_wdata = data;
        do @(negedge clk); while (busy);
        @(posedge clk);  // accepted here
        if (op)
            golden[{addr[31:2], 2'b00}] = strobe_merge(expected_load(addr), data, strb);
        else
            exp_q.push_back(expected_load(addr));
        #2 req_valid = 1'b0;
    endtask

    task automatic drain();
        do @(negedge clk); while (busy || rdata_valid || mem_rd_req || mem_wr_req);
        @(posedge clk);
        #2;
    endtask

    initial begin : watchdog
        repeat (16 + num_req * 40) @(posedge clk);
        $display("watchdog expired, the cache stopped answering");
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(51));
        value_errors = 0;
        other_errors = 0;
        test_name = "reset";
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = 1'b0;
        req_addr  = '0;
        req_wstrb = '0;
        req_wdata = '0;
        repeat (16) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #2 rst_n = 1'b1;
        @(negedge clk);
        check_idle();  // first cycle out of reset
        @(posedge clk);
        #2;

        test_name = "cold miss";  // set 3
        send(1'b0, 32'h0000_1230, 4'h0, '0);
        drain();
        assert (rd_addrs.size() == 1 && rd_addrs[0] == 32'h0000_1230)
        else protocol_fault("no refill request for the cold line");
        send(1'b0, 32'h0000_1234, 4'h0, '0);
        @(negedge clk);
        assert (rdata_valid && !busy) else protocol_fault("hit did not return in the next cycle");
        drain();

        test_name = "store bypass";  // back to back, same word
        send(1'b1, 32'h0000_1234, 4'b0101, 32'hdead_beef);
        send(1'b0, 32'h0000_1234, 4'h0, '0);
        drain();

        test_name = "dirty eviction";  // lines A, B, C of set 5
        wr_addrs.delete();
        send(1'b1, 32'h0000_2158, 4'b1100, 32'h1234_5678);
        send(1'b0, 32'h0000_2250, 4'h0, '0);
        send(1'b0, 32'h0000_2350, 4'h0, '0);
        drain();
        assert (wr_addrs.size() == 1 && wr_addrs[0] == 32'h0000_2150)
        else protocol_fault("dirty line A was not written back");
        send(1'b0, 32'h0000_2158, 4'h0, '0);
        drain();

        test_name = "lru choice";  // set 9, A ends up dirty and recent
        send(1'b0, 32'h0000_3190, 4'h0, '0);
        send(1'b0, 32'h0000_3290, 4'h0, '0);
        send(1'b0, 32'h0000_3194, 4'h0, '0);
        send(1'b1, 32'h0000_3198, 4'hf, 32'hc0ff_ee00);
        drain();
        rd_addrs.delete();
        wr_addrs.delete();
        send(1'b0, 32'h0000_3390, 4'h0, '0);
        drain();
        assert (wr_addrs.size() == 0) else protocol_fault("recently used line A was written back");
        assert (rd_addrs.size() == 1 && rd_addrs[0] == 32'h0000_3390)
        else protocol_fault("refill order wrong for line C");
        send(1'b0, 32'h0000_3198, 4'h0, '0);
        drain();
        assert (rd_addrs.size() == 1) else protocol_fault("line A evicted instead of line B");

        test_name = "random mix";  // 4 tags x 4 sets
        repeat (rand_req) begin
            send(1'($urandom % 2),
                 32'h4000 + (($urandom % 4) << 8) + (($urandom % 4) << 4) + (($urandom % 4) << 2),
                 strb_t'($urandom), $urandom);
        end
        drain();
        assert (exp_q.size() == 0) else protocol_fault("loads left without a response");

        $display("errors: %0d value, %0d protocol", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/dcache_top.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// dcache top
// 2-way write-back, write-allocate data cache with plain
// CPU request ports and a line wide memory port
////////////////////////////////////////////////////////////
module dcache_top #(
    parameter int set_num = 256
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  logic                          req_op,
    input  logic [dcache_pkg::addr_w-1:0] req_addr,
    input  dcache_pkg::strb_t             req_wstrb,
    input  dcache_pkg::word_t             req_wdata,
    output logic                          busy,
    output logic                          rdata_valid,
    output dcache_pkg::word_t             rdata,
    output logic                          mem_rd_req,
    output logic                          mem_wr_req,
    output logic [dcache_pkg::addr_w-1:0] mem_rd_addr,
    output logic [dcache_pkg::addr_w-1:0] mem_wr_addr,
    output dcache_pkg::line_t             mem_wr_data,
    input  logic                          mem_rd_rdy,
    input  logic                          mem_ret_valid,
    input  logic                          mem_wr_rdy,
    input  logic                          mem_wr_done,
    input  dcache_pkg::line_t             mem_ret_data
);
    import dcache_pkg::*;

    logic                       lru_way;    // victim of the pending set
    line_t                      line_rdata [way_num];
    logic                       lru_touch;
    way_vec_t                   lru_hit;
    logic [$clog2(set_num)-1:0] lru_index;

    dcache_array_if #(.set_num(set_num)) arr_if ();

    dcache_ctrl #(.set_num(set_num)) u_ctrl (
        .clk, .rst_n,
        .req_valid, .req_op, .req_addr, .req_wstrb, .req_wdata,
        .busy, .rdata_valid, .rdata,
        .mem_rd_req, .mem_rd_addr, .mem_rd_rdy, .mem_ret_valid, .mem_ret_data,
        .mem_wr_req, .mem_wr_addr, .mem_wr_rdy, .mem_wr_done,
        .arr(arr_if.ctrl),
        .lru_way, .line_rdata, .lru_touch, .lru_hit, .lru_index
    );

    dcache_tag_array #(.set_num(set_num)) u_tag (
        .clk, .rst_n, .arr(arr_if.tag), .victim_way(lru_way)
    );

    // victim line goes straight out as write-back data
    dcache_data_array #(.set_num(set_num)) u_data (
        .clk, .arr(arr_if.data), .victim_way(lru_way),
        .line_rdata, .victim_line(mem_wr_data)
    );

    dcache_lru #(.set_num(set_num)) u_lru (
        .clk, .rst_n, .touch(lru_touch), .hit(lru_hit), .index(lru_index), .lru_way
    );

endmodule

//--- verilog/dcache_ctrl.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// dcache control
// request register, hit decision, store commit register
// with load bypass, miss FSM and memory request drive
////////////////////////////////////////////////////////////
module dcache_ctrl #(
    parameter int set_num = 256
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req_valid,
    input  logic                           req_op,       // 1 is a store
    input  logic [dcache_pkg::addr_w-1:0]  req_addr,
    input  dcache_pkg::strb_t              req_wstrb,
    input  dcache_pkg::word_t              req_wdata,
    output logic                           busy,
    output logic                           rdata_valid,
    output dcache_pkg::word_t              rdata,
    output logic                           mem_rd_req,
    output logic [dcache_pkg::addr_w-1:0]  mem_rd_addr,
    input  logic                           mem_rd_rdy,
    input  logic                           mem_ret_valid,
    input  dcache_pkg::line_t              mem_ret_data,
    output logic                           mem_wr_req,
    output logic [dcache_pkg::addr_w-1:0]  mem_wr_addr,
    input  logic                           mem_wr_rdy,
    input  logic                           mem_wr_done,
    dcache_array_if.ctrl                   arr,
    input  logic                           lru_way,
    input  dcache_pkg::line_t              line_rdata [dcache_pkg::way_num],
    output logic                           lru_touch,
    output dcache_pkg::way_vec_t           lru_hit,
    output logic [$clog2(set_num)-1:0]     lru_index
);
    import dcache_pkg::*;

    localparam int index_w = $clog2(set_num);
    localparam int tag_w   = addr_w - index_w - offset_w;

    miss_state_t           state_q, state_d;
    logic                  req_valid_q;
    logic                  req_op_q;
    logic [addr_w-1:0]     req_addr_q;
    strb_t                 req_wstrb_q;
    word_t                 req_wdata_q;
    logic [index_w-1:0]    req_index;
    logic [tag_w-1:0]      req_tag;
    logic [word_sel_w-1:0] req_word;
    logic                  store_valid_q;
    way_vec_t              store_way_q;
    logic [index_w-1:0]    store_index_q;
    logic [word_sel_w-1:0] store_word_q;
    word_t                 store_data_q;
    way_vec_t              victim_vec;
    logic                  any_hit, hit_fire, refill_wr, bypass;
    word_t                 hit_word;

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input strb_t strb);
        word_t res;
        for (int b = 0; b < $bits(strb_t); b++) begin
            res[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return res;
    endfunction

    assign req_index = req_addr_q[offset_w +: index_w];
    assign req_tag   = req_addr_q[addr_w-1 -: tag_w];
    assign req_word  = get_word_sel(req_addr_q, index_w, tag_w);

    // idle lookup reads at the incoming set, otherwise the pending one
    assign arr.rd_index = (state_q == lookup && !req_valid_q) ?
                          req_addr[offset_w +: index_w] : req_index;
    assign arr.cmp_tag  = req_tag;

    assign any_hit  = |arr.hit;
    // refill_done always hits since the line was just written
    assign hit_fire = req_valid_q & any_hit & (state_q == lookup || state_q == refill_done);
    assign busy     = (state_q == lookup) ? (req_valid_q & ~any_hit) : (state_q != refill_done);
    assign rdata_valid = hit_fire & ~req_op_q;

    // uncommitted store to the same word and way
    assign bypass   = store_valid_q && (store_way_q == arr.hit) &&
                      (store_index_q == req_index) && (store_word_q == req_word);
    assign hit_word = bypass ? store_data_q :
                      line_rdata[arr.hit[1]][addr_w*req_word +: addr_w];
    assign rdata    = hit_word;

    assign victim_vec        = way_vec_t'(1) << lru_way;
    assign refill_wr         = (state_q == refill) & mem_ret_valid;
    assign arr.refill_way_we = refill_wr ? victim_vec : '0;
    assign arr.refill_line   = mem_ret_data;
    assign arr.wr_index      = (state_q == refill) ? req_index : store_index_q;
    assign arr.store_we      = store_valid_q ? store_way_q : '0;  // commit one cycle later
    assign arr.store_word    = store_word_q;
    assign arr.store_data    = store_data_q;

    // refill counts as an access to the victim way
    assign lru_touch = hit_fire | refill_wr;
    assign lru_hit   = refill_wr ? victim_vec : arr.hit;
    assign lru_index = req_index;

    assign mem_rd_req  = (state_q == miss_clean);
    assign mem_wr_req  = (state_q == miss_dirty);
    assign mem_rd_addr = {req_tag, req_index, {offset_w{1'b0}}};         // line aligned
    assign mem_wr_addr = {arr.victim_tag, req_index, {offset_w{1'b0}}};

    always_comb begin
        state_d = state_q;
        case (state_q)
            lookup: begin
                if (req_valid_q && !any_hit) begin
                    state_d = arr.victim_dirty ? miss_dirty : miss_clean;
                end
            end
            miss_dirty:  if (mem_wr_rdy) state_d = write_back;
            write_back:  if (mem_wr_done) state_d = miss_clean;
            miss_clean:  if (mem_rd_rdy) state_d = refill;
            refill:      if (mem_ret_valid) state_d = refill_done;
            refill_done: state_d = lookup;
            default:     state_d = lookup;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= lookup;
            req_valid_q   <= 1'b0;
            store_valid_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            store_valid_q <= hit_fire & req_op_q;
            if (!busy) begin
                req_valid_q <= req_valid;  // empty slot when nothing is offered
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            req_op_q    <= req_op;
            req_addr_q  <= req_addr;
            req_wstrb_q <= req_wstrb;
            req_wdata_q <= req_wdata;
        end
        if (hit_fire && req_op_q) begin
            store_way_q   <= arr.hit;
            store_index_q <= req_index;
            store_word_q  <= req_word;
            store_data_q  <= merge_bytes(hit_word, req_wdata_q, req_wstrb_q);
        end
    end

    // the refilled line is found at the pending set and tag
    assert property (@(posedge clk) disable iff (!rst_n) (state_q == refill_done) |-> any_hit);
    // a line lives in one way only
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(arr.hit));

endmodule

//--- verilog/dcache_lru.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// dcache lru
// one bit per set naming the least recently used way
////////////////////////////////////////////////////////////
module dcache_lru #(
    parameter int set_num = 256
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       touch,
    input  dcache_pkg::way_vec_t       hit,    // accessed way, one-hot
    input  logic [$clog2(set_num)-1:0] index,
    output logic                       lru_way
);
    import dcache_pkg::*;

    logic [set_num-1:0] lru_q;  // 0 -> way 0 is the victim

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (touch) begin
            if (hit[0]) begin
                lru_q[index] <= 1'b1;  // point away from way 0
            end else if (hit[way_num-1]) begin
                lru_q[index] <= 1'b0;
            end
        end
    end

    assign lru_way = lru_q[index];

endmodule

//--- verilog/dcache_data_array.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// dcache data array
// per way, per word line storage with a full line refill
// port and a single word store port
////////////////////////////////////////////////////////////
module dcache_data_array #(
    parameter int set_num = 256
) (
    input  logic                clk,
    dcache_array_if.data        arr,
    input  logic                victim_way,
    output dcache_pkg::line_t   line_rdata [dcache_pkg::way_num],
    output dcache_pkg::line_t   victim_line
);
    import dcache_pkg::*;

    word_t data_mem [way_num][set_num][line_word_num];

    // refill wins over a store, the two never overlap in practice
    always_ff @(posedge clk) begin
        for (int w = 0; w < way_num; w++) begin
            if (arr.refill_way_we[w]) begin
                for (int i = 0; i < line_word_num; i++) begin
                    data_mem[w][arr.wr_index][i] <= arr.refill_line[addr_w*i +: addr_w];
                end
            end else if (arr.store_we[w]) begin
                data_mem[w][arr.wr_index][arr.store_word] <= arr.store_data;  // merged word
            end
        end
    end

    // every way read at once for the hit mux
    always_comb begin
        for (int w = 0; w < way_num; w++) begin
            for (int i = 0; i < line_word_num; i++) begin
                line_rdata[w][addr_w*i +: addr_w] = data_mem[w][arr.rd_index][i];
            end
        end
    end

    assign victim_line = line_rdata[victim_way];  // write-back payload

endmodule

//--- verilog/dcache_tag_array.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// dcache tag array
// valid, tag and dirty per way and set, hit compare at the
// read index and victim tag and dirty readout
////////////////////////////////////////////////////////////
module dcache_tag_array #(
    parameter int set_num = 256
) (
    input  logic          clk,
    input  logic          rst_n,
    dcache_array_if.tag   arr,
    input  logic          victim_way   // lru choice at the read index
);
    import dcache_pkg::*;

    localparam int index_w = $clog2(set_num);
    localparam int tag_w   = addr_w - index_w - offset_w;

    logic [set_num-1:0] valid_q [way_num];
    logic [tag_w-1:0]   tag_mem [way_num][set_num];
    logic               dirty_mem [way_num][set_num];

    // valid bits per way and set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < way_num; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < way_num; w++) begin
                if (arr.refill_way_we[w]) begin
                    valid_q[w][arr.wr_index] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < way_num; w++) begin
            if (arr.refill_way_we[w]) begin
                tag_mem[w][arr.wr_index]   <= arr.cmp_tag;  // tag of the missing request
                dirty_mem[w][arr.wr_index] <= 1'b0;         // fresh line is clean
            end else if (arr.store_we[w]) begin
                dirty_mem[w][arr.wr_index] <= 1'b1;         // store commit marks it
            end
        end
    end

    always_comb begin
        for (int w = 0; w < way_num; w++) begin
            arr.hit[w] = valid_q[w][arr.rd_index] &&
                         (tag_mem[w][arr.rd_index] == arr.cmp_tag);
        end
    end

    assign arr.victim_tag   = tag_mem[victim_way][arr.rd_index];
    // invalid lines never need a write-back
    assign arr.victim_dirty = valid_q[victim_way][arr.rd_index] &
                              dirty_mem[victim_way][arr.rd_index];

endmodule

//--- verilog/dcache_array_if.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// dcache array bus
// index, tag, hit and write enables between the control
// and the tag and data arrays
////////////////////////////////////////////////////////////
interface dcache_array_if #(
    parameter int set_num = 256
);
    import dcache_pkg::*;

    localparam int index_w = $clog2(set_num);
    localparam int tag_w   = addr_w - index_w - offset_w;

    logic [index_w-1:0]    rd_index;      // combinational read set
    logic [tag_w-1:0]      cmp_tag;       // also the tag written on refill
    way_vec_t              hit;
    logic [tag_w-1:0]      victim_tag;
    logic                  victim_dirty;
    way_vec_t              refill_way_we;
    logic [index_w-1:0]    wr_index;      // refill or store commit set
    way_vec_t              store_we;
    logic [word_sel_w-1:0] store_word;
    word_t                 store_data;
    line_t                 refill_line;

    modport ctrl (
        output rd_index, cmp_tag, refill_way_we, wr_index,
        output store_we, store_word, store_data, refill_line,
        input  hit, victim_tag, victim_dirty
    );

    modport tag (
        input  rd_index, cmp_tag, refill_way_we, wr_index, store_we,
        output hit, victim_tag, victim_dirty
    );

    modport data (
        input rd_index, refill_way_we, wr_index,
        input store_we, store_word, store_data, refill_line
    );

endinterface

//--- verilog/dcache_pkg.sv
////////////////////////////////////////////////////////////
// dcache shared definitions
// widths and line layout of the 2-way data cache, the miss
// FSM state encoding and the address field helpers
////////////////////////////////////////////////////////////
package dcache_pkg;

    localparam int addr_w        = 32;  // address and data width
    localparam int way_num       = 2;   // fixed, lru is a single bit
    localparam int line_word_num = 4;   // 16 byte lines
    localparam int offset_w      = 4;   // byte offset within a line
    localparam int word_sel_w    = $clog2(line_word_num);
    localparam int byte_sel_w    = $clog2(addr_w / 8);

    typedef logic [line_word_num*addr_w-1:0] line_t;  // word 0 in the low bits
    typedef logic [addr_w-1:0]               word_t;
    typedef logic [addr_w/8-1:0]             strb_t;  // one bit per byte lane
    typedef logic [way_num-1:0]              way_vec_t;

    // miss sequence, clean victims go straight to miss_clean
    typedef enum logic [2:0] {
        lookup,
        miss_dirty,   // write-back request out
        write_back,   // waiting for the write to finish
        miss_clean,   // refill request out
        refill,       // waiting for the line
        refill_done   // line written, request completes here
    } miss_state_t;

    // offset is whatever is left below index and tag
    function automatic logic [offset_w-1:0] get_offset(
        input logic [addr_w-1:0] addr,
        input int unsigned       index_w,
        input int unsigned       tag_w
    );
        word_t mask;
        mask = (word_t'(1) << (addr_w - index_w - tag_w)) - word_t'(1);
        return offset_w'(addr & mask);
    endfunction

    // word number inside the line
    function automatic logic [word_sel_w-1:0] get_word_sel(
        input logic [addr_w-1:0] addr,
        input int unsigned       index_w,
        input int unsigned       tag_w
    );
        return word_sel_w'(get_offset(addr, index_w, tag_w) >> byte_sel_w);
    endfunction

endpackage
